/* src/matmul_pkg.sv */
package matmul_pkg;

  // SRAM word width
  localparam int DATA_W = 32;

  // One dimension field, half of a word
  localparam int DIM_W = 16;

  // Dimension header, rows in the upper half-word
  typedef struct packed {
    logic [DIM_W-1:0] rows;
    logic [DIM_W-1:0] cols;
  } dims_t;

  // Word at address 0 is a header, every other word is an element
  typedef union packed {
    dims_t             dims;
    logic [DATA_W-1:0] data;
  } sram_word_u;

  // Travels with each operand address pair
  typedef struct packed {
    logic valid;
    // First element of a dot product
    logic first;
    // Last element of a dot product
    logic last;
    // Last element of the whole job
    logic is_final;
  } op_tag_t;

  // One finished element of C
  typedef struct packed {
    logic              valid;
    // Last element of C in this job
    logic              is_final;
    logic [DATA_W-1:0] data;
  } result_t;

endpackage

/* src/matmul_ctrl.sv */
`timescale 1ns/1ns

module matmul_ctrl (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   dut_valid,
  input  matmul_pkg::sram_word_u input_header,
  input  matmul_pkg::sram_word_u weight_header,
  input  logic                   job_done,
  output logic                   dut_ready,
  output logic                   header_select,
  output logic                   start_stream,
  output matmul_pkg::dims_t      dims_a,
  output matmul_pkg::dims_t      dims_b
);

  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    HDR_ADDR = 3'd1,
    HDR_CAP  = 3'd2,
    STREAM   = 3'd3,
    DONE     = 3'd4
  } state_t;

  state_t state;
  state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      IDLE, DONE: begin
        // Strobe only counts while ready is high
        if (dut_valid) begin
          state_next = HDR_ADDR;
        end else begin
          state_next = IDLE;
        end
      end
      HDR_ADDR: begin
        state_next = HDR_CAP;
      end
      HDR_CAP: begin
        state_next = STREAM;
      end
      STREAM: begin
        // Writer flags the last C element
        if (job_done) begin
          state_next = DONE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state        <= IDLE;
      start_stream <= 1'b0;
    end else begin
      state        <= state_next;
      start_stream <= (state == HDR_CAP);
    end
  end

  // Header data is back one cycle after address 0 was shown
  always_ff @(posedge clk) begin
    if (state == HDR_CAP) begin
      dims_a <= input_header.dims;
      dims_b <= weight_header.dims;
    end
  end

  // Ready in idle and in the cycle after the final write
  assign dut_ready     = (state == IDLE) || (state == DONE);
  assign header_select = (state == HDR_ADDR);

endmodule

/* src/operand_addr_gen.sv */
`timescale 1ns/1ns

module operand_addr_gen #(
  parameter int ADDR_W = 16
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start_stream,
  input  logic                    header_select,
  input  matmul_pkg::dims_t       dims_a,
  input  matmul_pkg::dims_t       dims_b,
  output logic [ADDR_W-1:0]       input_read_address,
  output logic [ADDR_W-1:0]       weight_read_address,
  output matmul_pkg::op_tag_t     tag
);

  logic [matmul_pkg::DIM_W-1:0] i_cnt, j_cnt, k_cnt;
  logic [matmul_pkg::DIM_W-1:0] i_next, j_next, k_next;
  logic [matmul_pkg::DIM_W-1:0] i_max, j_max, k_max;
  logic [ADDR_W-1:0]            a_row_base, b_col_base;
  logic [ADDR_W-1:0]            a_base_next, b_base_next;
  logic [ADDR_W-1:0]            a_addr, b_addr;
  logic [ADDR_W-1:0]            a_addr_next, b_addr_next;
  logic [ADDR_W-1:0]            k_step;
  logic                         advance;

  // K from the column count of A, N from the column count of B
  assign i_max  = dims_a.rows - 1'b1;
  assign j_max  = dims_b.cols - 1'b1;
  assign k_max  = dims_a.cols - 1'b1;
  assign k_step = ADDR_W'(dims_a.cols);

  // Keep issuing until the final element has gone out
  assign advance = start_stream || (tag.valid && !tag.is_final);

  always_comb begin
    i_next      = i_cnt;
    j_next      = j_cnt;
    k_next      = k_cnt + 1'b1;
    a_base_next = a_row_base;
    b_base_next = b_col_base;
    a_addr_next = a_addr + 1'b1;
    b_addr_next = b_addr + 1'b1;
    if (start_stream) begin
      i_next      = '0;
      j_next      = '0;
      k_next      = '0;
      a_base_next = ADDR_W'(1);
      b_base_next = ADDR_W'(1);
      a_addr_next = ADDR_W'(1);
      b_addr_next = ADDR_W'(1);
    end else if (k_cnt == k_max) begin
      k_next = '0;
      if (j_cnt == j_max) begin
        // Next row of A, back to the first column of B
        j_next      = '0;
        i_next      = i_cnt + 1'b1;
        a_base_next = a_row_base + k_step;
        b_base_next = ADDR_W'(1);
      end else begin
        j_next      = j_cnt + 1'b1;
        b_base_next = b_col_base + k_step;
      end
      a_addr_next = a_base_next;
      b_addr_next = b_base_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      i_cnt      <= '0;
      j_cnt      <= '0;
      k_cnt      <= '0;
      a_row_base <= '0;
      b_col_base <= '0;
      a_addr     <= '0;
      b_addr     <= '0;
      tag        <= '0;
    end else if (advance) begin
      i_cnt          <= i_next;
      j_cnt          <= j_next;
      k_cnt          <= k_next;
      a_row_base     <= a_base_next;
      b_col_base     <= b_base_next;
      a_addr         <= a_addr_next;
      b_addr         <= b_addr_next;
      tag.valid      <= 1'b1;
      tag.first      <= (k_next == '0);
      tag.last       <= (k_next == k_max);
      tag.is_final   <= (k_next == k_max) && (j_next == j_max) && (i_next == i_max);
    end else begin
      tag <= '0;
    end
  end

  // Header word sits at address 0 of both SRAMs
  assign input_read_address  = header_select ? '0 : a_addr;
  assign weight_read_address = header_select ? '0 : b_addr;

endmodule

/* src/mac_unit.sv */
`timescale 1ns/1ns

module mac_unit (
  input  logic                   clk,
  input  logic                   reset_n,
  input  matmul_pkg::op_tag_t    tag,
  input  matmul_pkg::sram_word_u a_word,
  input  matmul_pkg::sram_word_u b_word,
  output matmul_pkg::result_t    result
);

  matmul_pkg::op_tag_t          tag_d;
  logic [matmul_pkg::DATA_W-1:0] product;
  logic [matmul_pkg::DATA_W-1:0] sum;
  logic [matmul_pkg::DATA_W-1:0] acc;

  // Tag lines up with the SRAM read latency
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tag_d <= '0;
    end else begin
      tag_d <= tag;
    end
  end

  // Low 32 bits only, wraps like the reference model
  assign product = a_word.data * b_word.data;
  assign sum     = tag_d.first ? product : acc + product;

  always_ff @(posedge clk) begin
    if (tag_d.valid) begin
      acc <= sum;
    end
  end

  // Result comes out one cycle after the last element
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result <= '0;
    end else begin
      result.valid    <= tag_d.valid && tag_d.last;
      result.is_final <= tag_d.valid && tag_d.last && tag_d.is_final;
      result.data     <= sum;
    end
  end

endmodule

/* src/result_writer.sv */
`timescale 1ns/1ns

module result_writer #(
  parameter int ADDR_W = 16
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  matmul_pkg::result_t           result,
  output logic                          result_write_enable,
  output logic [ADDR_W-1:0]             result_write_address,
  output logic [matmul_pkg::DATA_W-1:0] result_write_data,
  output logic                          job_done
);

  // Address of the next element of C
  logic [ADDR_W-1:0] wr_cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result_write_enable <= 1'b0;
      job_done            <= 1'b0;
      wr_cnt              <= '0;
    end else begin
      result_write_enable <= result.valid;
      job_done            <= result.valid && result.is_final;
      if (result.valid) begin
        // Next job starts again at address 0
        if (result.is_final) begin
          wr_cnt <= '0;
        end else begin
          wr_cnt <= wr_cnt + 1'b1;
        end
      end
    end
  end

  // Write port payload
  always_ff @(posedge clk) begin
    if (result.valid) begin
      result_write_address <= wr_cnt;
      result_write_data    <= result.data;
    end
  end

endmodule

/* src/matmul_top.sv */
`timescale 1ns/1ns

module matmul_top #(
  parameter int ADDR_W = 16
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          dut_valid,
  output logic                          dut_ready,

  output logic [ADDR_W-1:0]             input_read_address,
  input  matmul_pkg::sram_word_u        input_read_data,

  output logic [ADDR_W-1:0]             weight_read_address,
  input  matmul_pkg::sram_word_u        weight_read_data,

  output logic                          result_write_enable,
  output logic [ADDR_W-1:0]             result_write_address,
  output logic [matmul_pkg::DATA_W-1:0] result_write_data
);

  matmul_pkg::dims_t   dims_a;
  matmul_pkg::dims_t   dims_b;
  matmul_pkg::op_tag_t tag;
  matmul_pkg::result_t result;
  logic                header_select;
  logic                start_stream;
  logic                job_done;

  matmul_ctrl u_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .input_header  (input_read_data),
    .weight_header (weight_read_data),
    .job_done      (job_done),
    .dut_ready     (dut_ready),
    .header_select (header_select),
    .start_stream  (start_stream),
    .dims_a        (dims_a),
    .dims_b        (dims_b)
  );

  operand_addr_gen #(
    .ADDR_W (ADDR_W)
  ) u_addr_gen (
    .clk                 (clk),
    .reset_n             (reset_n),
    .start_stream        (start_stream),
    .header_select       (header_select),
    .dims_a              (dims_a),
    .dims_b              (dims_b),
    .input_read_address  (input_read_address),
    .weight_read_address (weight_read_address),
    .tag                 (tag)
  );

  mac_unit u_mac (
    .clk     (clk),
    .reset_n (reset_n),
    .tag     (tag),
    .a_word  (input_read_data),
    .b_word  (weight_read_data),
    .result  (result)
  );

  result_writer #(
    .ADDR_W (ADDR_W)
  ) u_writer (
    .clk                  (clk),
    .reset_n              (reset_n),
    .result               (result),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data),
    .job_done             (job_done)
  );

endmodule

/* tb/matmul_checker.sv */
`timescale 1ns/1ns

module matmul_checker (
  input logic clk,
  input logic reset_n,
  input logic dut_valid,
  input logic dut_ready,
  input logic result_write_enable,
  input logic job_done
);

  // Failed properties so far, watched from the testbench top
  int unsigned fail_count = 0;

  // Engine idle and write port quiet once reset has been seen
  a_reset_idle: assert property (
    @(posedge clk) !reset_n |=> (dut_ready && !result_write_enable)
  ) else begin
    $error("engine not idle after reset");
    fail_count++;
  end

  // Accepted strobe drops ready on the next edge
  a_start_drops_ready: assert property (
    @(posedge clk) disable iff (!reset_n) (dut_valid && dut_ready) |=> !dut_ready
  ) else begin
    $error("ready still high after an accepted start");
    fail_count++;
  end

  // Ready only comes back the cycle after the final write
  a_ready_after_final: assert property (
    @(posedge clk) disable iff (!reset_n)
      $rose(dut_ready) |-> $past(job_done && result_write_enable)
  ) else begin
    $error("ready rose without a final write in the cycle before");
    fail_count++;
  end

  // No writes outside a job
  a_no_stray_write: assert property (
    @(posedge clk) disable iff (!reset_n) dut_ready |-> !result_write_enable
  ) else begin
    $error("result write while the engine is ready");
    fail_count++;
  end

endmodule

/* tb/matmul_tb.sv */
`timescale 1ns/1ns

module matmul_tb;

  localparam int ADDR_W    = 16;
  localparam int MEM_DEPTH = 1 << ADDR_W;
  localparam int NUM_JOBS  = 3;
  // 3 jobs x (64 elements + 20 overhead) x 2, rounded up
  localparam int TIMEOUT_CYCLES = 600;

  logic                          clk;
  logic                          reset_n;
  logic                          dut_valid;
  logic                          dut_ready;
  logic [ADDR_W-1:0]             input_read_address;
  matmul_pkg::sram_word_u        input_read_data;
  logic [ADDR_W-1:0]             weight_read_address;
  matmul_pkg::sram_word_u        weight_read_data;
  logic                          result_write_enable;
  logic [ADDR_W-1:0]             result_write_address;
  logic [matmul_pkg::DATA_W-1:0] result_write_data;

  // SRAM contents
  logic [31:0]       mem_a [MEM_DEPTH];
  logic [31:0]       mem_b [MEM_DEPTH];
  logic [31:0]       mem_c [MEM_DEPTH];
  logic [ADDR_W-1:0] a_addr_q;
  logic [ADDR_W-1:0] b_addr_q;

  logic [31:0] lfsr_state;
  int unsigned cycle_count;
  int unsigned write_count;
  int          job_m;
  int          job_n;
  int          job_k;
  logic [31:0] a_vals [$];
  logic [31:0] b_vals [$];
  logic [31:0] expected_c [$];

  matmul_top #(
    .ADDR_W (ADDR_W)
  ) dut (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  bind matmul_top matmul_checker u_checker (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .dut_ready           (dut_ready),
    .result_write_enable (result_write_enable),
    .job_done            (job_done)
  );

  always #2 clk = ~clk;

  // Read SRAMs, address taken at the edge, data out shortly after
  always @(posedge clk) begin
    a_addr_q = input_read_address;
    b_addr_q = weight_read_address;
    #1;
    input_read_data  = mem_a[a_addr_q];
    weight_read_data = mem_b[b_addr_q];
  end

  // Result SRAM
  always @(posedge clk) begin
    if (result_write_enable) begin
      mem_c[result_write_address] <= result_write_data;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure("Timeout: the jobs did not finish within the cycle limit");
      $fatal(1, "cycle limit reached");
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    assert (dut.u_checker.fail_count == 0)
      else begin
        report_failure("A protocol assertion in the bound checker failed");
        $fatal(1, "checker assertion failed");
      end
    if (reset_n && result_write_enable) begin
      assert (write_count < job_m * job_n)
        else begin
          report_failure("More result writes than elements of C in this job");
          $fatal(1, "extra write");
        end
      assert (result_write_address == ADDR_W'(write_count))
        else begin
          report_failure($sformatf("MISMATCH result_write_address: got 0x%0h, expected 0x%0h",
                                   result_write_address, write_count));
          $fatal(1, "wrong write address");
        end
      assert (result_write_data == expected_c[write_count])
        else begin
          report_failure($sformatf("MISMATCH result_write_data: got 0x%0h, expected 0x%0h",
                                   result_write_data, expected_c[write_count]));
          $fatal(1, "wrong write data");
        end
      write_count++;
    end
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
  endtask

  // Galois LFSR, right shift, x^32+x^30+x^26+x^25+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'hA300_0000;
    end
    return next;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int width, output logic [31:0] value);
    int b;
    value = '0;
    for (b = 0; b < width; b++) begin
      value[b]   = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Every word differs, so a stray read shows up in the results
  task automatic fill_memories();
    int addr;
    for (addr = 0; addr < MEM_DEPTH; addr++) begin
      mem_a[ADDR_W'(addr)] = (32'(addr) * 32'h9E37_79B9) ^ 32'h1357_9BDF;
      mem_b[ADDR_W'(addr)] = (32'(addr) * 32'h85EB_CA6B) ^ 32'h2468_ACE0;
      mem_c[ADDR_W'(addr)] = (32'(addr) * 32'hC2B2_AE35) ^ 32'h0F0F_F0F0;
    end
  endtask

  // Random sizes and elements, then C = A x B with 32-bit wrap
  task automatic load_job();
    logic [31:0]       raw;
    logic [31:0]       sum;
    matmul_pkg::dims_t hdr;
    int                i;
    int                j;
    int                k;
    a_vals.delete();
    b_vals.delete();
    expected_c.delete();
    draw_bits(2, raw);
    job_m = int'(raw[1:0]) + 1;
    draw_bits(2, raw);
    job_n = int'(raw[1:0]) + 1;
    draw_bits(2, raw);
    job_k = int'(raw[1:0]) + 1;
    hdr.rows = 16'(job_m);
    hdr.cols = 16'(job_k);
    mem_a[0] = hdr;
    hdr.rows = 16'(job_k);
    hdr.cols = 16'(job_n);
    mem_b[0] = hdr;
    // A row-major, B column by column, both from address 1
    for (i = 0; i < job_m * job_k; i++) begin
      draw_bits(8, raw);
      a_vals.push_back({{24{raw[7]}}, raw[7:0]});
      mem_a[ADDR_W'(1 + i)] = a_vals[i];
    end
    for (i = 0; i < job_k * job_n; i++) begin
      draw_bits(8, raw);
      b_vals.push_back({{24{raw[7]}}, raw[7:0]});
      mem_b[ADDR_W'(1 + i)] = b_vals[i];
    end
    for (i = 0; i < job_m; i++) begin
      for (j = 0; j < job_n; j++) begin
        sum = '0;
        for (k = 0; k < job_k; k++) begin
          sum = sum + a_vals[i * job_k + k] * b_vals[j * job_k + k];
        end
        expected_c.push_back(sum);
      end
    end
  endtask

  task automatic run_job();
    int idx;
    while (!dut_ready) begin
      @(negedge clk);
    end
    load_job();
    write_count = 0;
    @(posedge clk);
    #1;
    dut_valid = 1'b1;
    @(posedge clk);
    #1;
    dut_valid = 1'b0;
    @(negedge clk);
    while (!dut_ready) begin
      @(negedge clk);
    end
    assert (write_count == job_m * job_n)
      else begin
        report_failure($sformatf("MISMATCH write count: got 0x%0h, expected 0x%0h",
                                 write_count, job_m * job_n));
        $fatal(1, "wrong number of writes");
      end
    // Result SRAM holds all of C
    for (idx = 0; idx < job_m * job_n; idx++) begin
      assert (mem_c[ADDR_W'(idx)] == expected_c[idx])
        else begin
          report_failure($sformatf("MISMATCH mem_c[0x%0h]: got 0x%0h, expected 0x%0h",
                                   idx, mem_c[ADDR_W'(idx)], expected_c[idx]));
          $fatal(1, "wrong result SRAM content");
        end
    end
  endtask

  initial begin
    int job;
    clk              = 1'b0;
    reset_n          = 1'b0;
    dut_valid        = 1'b0;
    input_read_data  = '0;
    weight_read_data = '0;
    lfsr_state       = 32'h7b2;
    cycle_count      = 0;
    write_count      = 0;
    job_m            = 1;
    job_n            = 1;
    job_k            = 1;
    fill_memories();
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    for (job = 0; job < NUM_JOBS; job++) begin
      run_job();
    end
    if (dut.u_checker.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_failure("A protocol assertion in the bound checker failed");
      $fatal(1, "checker assertion failed");
    end
  end

endmodule

/* src.f */
src/matmul_pkg.sv
src/matmul_ctrl.sv
src/operand_addr_gen.sv
src/mac_unit.sv
src/result_writer.sv
src/matmul_top.sv
tb/matmul_checker.sv
tb/matmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the matmul testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module matmul_tb -f src.f -o matmul_sim \
  && ./obj_dir/matmul_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log 2>/dev/null && echo "run_sim: passed" && exit 0 \
  || echo "run_sim: failed"
exit 1
